/* source/playfield_macros.svh */
// Width and count constants shared by the playfield RTL.
// Include wherever a port, type or array size depends on them.

`ifndef PLAYFIELD_MACROS_SVH
`define PLAYFIELD_MACROS_SVH

// video RAM bus
`define PF_ADDR_W       16      // word address width
`define PF_WORD_W       16      // data word width

// pixel group geometry
`define PF_LANES        8       // pixels expanded from one group
`define PF_MAX_WORDS    4       // words per group in 8 bpp

// line control counters
`define PF_REP_W        2       // h and v repeat count width
`define PF_GROUPS_W     8       // groups per line count width

`endif

/* source/pf_video_pkg.sv */
// Pixel format types for the playfield.
// Depth codes, colour indices and the 1 bpp attribute byte layout.

package pf_video_pkg;

    // depth code, as written by the host
    // code 3 is not named and decodes like BPP_8
    typedef enum logic [1:0] {
        BPP_1_ATTR = 2'd0,          // 1 word per group, attribute in high byte
        BPP_4      = 2'd1,          // 2 words per group
        BPP_8      = 2'd2           // 4 words per group
    } bpp_mode_e;

    // 8-bit colour index sent to the palette
    typedef logic [7:0] color_t;

    // high byte of word0 in 1 bpp mode
    // back nibble sits above fore, as in bits 15..12 / 11..8
    typedef struct packed {
        logic [3:0] back;           // colour for clear pixel bits
        logic [3:0] fore;           // colour for set pixel bits
    } attr_t;

    // lsb of the attribute byte inside word0
    localparam int ATTR_LSB = 8;

endpackage

/* source/pf_bus_pkg.sv */
// Memory bus side types for the playfield.
// Video RAM word address, data word and the fetch FSM states.

`include "playfield_macros.svh"

package pf_bus_pkg;

    // word address into video RAM
    typedef logic [`PF_ADDR_W-1:0] addr_t;

    // one display data word
    typedef logic [`PF_WORD_W-1:0] word_t;

    // fetch sequencer states
    typedef enum logic [2:0] {
        IDLE,                       // waiting for line start
        REQ,                        // set up address for next word
        WAIT_ACK,                   // cyc/stb up, waiting for slave ack
        HANDOFF,                    // group complete, bundle valid
        LINE_END                    // last group handed off, step line address
    } fetch_state_e;

endpackage

/* source/pf_ifs.sv */
// Internal interfaces of the playfield.
// word_bundle_if moves a fetched group from fetch to lanes and shifter,
// pixel_row_if carries the eight expanded lane outputs to the shifter.

`include "playfield_macros.svh"

interface word_bundle_if
    import pf_video_pkg::*;
    import pf_bus_pkg::*;
();

    word_t [`PF_MAX_WORDS-1:0] words;   // words[0] is the first fetched
    bpp_mode_e                 mode;    // depth the words were fetched for
    logic                      valid;   // all words of the group are in
    logic                      ready;   // shifter pending buffer is empty

    modport source (                    // fetch side
        output words,
        output mode,
        output valid,
        input  ready
    );

    modport sink_view (                 // lanes only look at the data
        input  words,
        input  mode
    );

    modport sink_ready (                // shifter does the handshake
        input  valid,
        output ready
    );

endinterface

interface pixel_row_if
    import pf_video_pkg::*;
();

    color_t [`PF_LANES-1:0] pixels;     // pixels[0] is leftmost, driven per lane

    modport sink (
        input  pixels
    );

endinterface

/* source/display_fetch.sv */
// Wishbone classic read master and line/group sequencer.
// Reads 1, 2 or 4 words per group from the line start address and hands each
// completed group to the shifter; steps the line address per vertical repeat.

`include "playfield_macros.svh"

module display_fetch
    import pf_video_pkg::*;
    import pf_bus_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    line_start_i,       // one cycle, honoured in IDLE
    input  logic                    frame_start_i,      // reload line start address
    input  addr_t                   start_addr_i,       // first line address of frame
    input  word_t                   line_len_i,         // words per display line
    input  logic [`PF_GROUPS_W-1:0] groups_i,           // groups in this line
    input  bpp_mode_e               mode_i,             // depth, latched at line start
    input  logic [`PF_REP_W-1:0]    v_repeat_i,         // extra times each line repeats
    output logic                    wb_cyc_o,
    output logic                    wb_stb_o,
    output logic                    wb_we_o,
    output addr_t                   wb_adr_o,
    input  word_t                   wb_dat_i,
    input  logic                    wb_ack_i,
    output logic                    line_fetched_o,     // pulse after last group handed off
    word_bundle_if.source           bundle_if
);

    localparam int IDX_W = $clog2(`PF_MAX_WORDS);

    fetch_state_e               state_q;
    addr_t                      line_addr_q;            // start of current display line
    addr_t                      addr_q;                 // next word to read
    logic [`PF_REP_W-1:0]       v_count_q;              // lines left before address steps
    logic [`PF_GROUPS_W-1:0]    group_cnt_q;            // groups left in the line
    logic [IDX_W-1:0]           word_idx_q;             // word slot being filled
    logic [IDX_W-1:0]           last_idx;               // final slot for this depth
    word_t [`PF_MAX_WORDS-1:0]  words_q;                // group being assembled
    bpp_mode_e                  mode_q;                 // depth for this line

    // number of words per group follows the depth
    always_comb begin
        case (mode_q)
            BPP_1_ATTR: last_idx = IDX_W'(0);
            BPP_4:      last_idx = IDX_W'(1);
            default:    last_idx = IDX_W'(`PF_MAX_WORDS - 1);   // 8 bpp and code 3
        endcase
    end

    // one outstanding read, cyc and stb only while waiting for ack
    assign wb_cyc_o = (state_q == WAIT_ACK);
    assign wb_stb_o = (state_q == WAIT_ACK);
    assign wb_we_o  = 1'b0;                             // read only master
    assign wb_adr_o = addr_q;                           // stable from REQ until ack

    assign line_fetched_o = (state_q == LINE_END);

    assign bundle_if.words = words_q;
    assign bundle_if.mode  = mode_q;
    assign bundle_if.valid = (state_q == HANDOFF);      // held until shifter takes it

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q     <= IDLE;
            line_addr_q <= '0;
            v_count_q   <= '0;
            group_cnt_q <= '0;
            word_idx_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (line_start_i) begin
                        addr_q      <= line_addr_q;     // every line restarts at line start
                        mode_q      <= mode_i;
                        group_cnt_q <= groups_i;
                        word_idx_q  <= '0;
                        if (groups_i == '0) begin
                            state_q <= LINE_END;        // empty line still steps vertically
                        end else begin
                            state_q <= REQ;
                        end
                    end
                end
                REQ: begin
                    state_q <= WAIT_ACK;                // raise cyc/stb next cycle
                end
                WAIT_ACK: begin
                    if (wb_ack_i) begin
                        words_q[word_idx_q] <= wb_dat_i;
                        addr_q              <= addr_q + 1'b1;
                        if (word_idx_q == last_idx) begin
                            state_q <= HANDOFF;         // group complete
                        end else begin
                            word_idx_q <= word_idx_q + 1'b1;
                            state_q    <= REQ;
                        end
                    end
                end
                HANDOFF: begin
                    if (bundle_if.ready) begin          // transfer happens this cycle
                        group_cnt_q <= group_cnt_q - 1'b1;
                        word_idx_q  <= '0;
                        if (group_cnt_q == `PF_GROUPS_W'(1)) begin
                            state_q <= LINE_END;
                        end else begin
                            state_q <= REQ;             // overlaps with shifter output
                        end
                    end
                end
                LINE_END: begin
                    // address steps only once the line has been shown v_repeat+1 times
                    if (v_count_q == '0) begin
                        line_addr_q <= line_addr_q + line_len_i;
                        v_count_q   <= v_repeat_i;
                    end else begin
                        v_count_q   <= v_count_q - 1'b1;
                    end
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase

            // new frame wins over the line end step
            if (frame_start_i) begin
                line_addr_q <= start_addr_i;
                v_count_q   <= v_repeat_i;              // restart vertical repeat
            end
        end
    end

endmodule

/* source/pixel_lane_expand.sv */
// One pixel lane: picks the colour index for position LANE out of the
// current word bundle according to depth, then applies the colour base.

`include "playfield_macros.svh"

module pixel_lane_expand
    import pf_video_pkg::*;
    import pf_bus_pkg::*;
#(
    parameter int LANE = 0                              // 0 is leftmost pixel
) (
    input  color_t                  colorbase_i,        // XOR'd into every index
    word_bundle_if.sink_view        bundle_if,
    output color_t                  pixel_o
);

    localparam int BIT_POS   = `PF_LANES - 1 - LANE;    // 1 bpp, msb is leftmost
    localparam int NIB_WORD  = LANE / 4;                // 4 bpp, four pixels per word
    localparam int NIB_LSB   = 12 - 4 * (LANE % 4);     // high nibble first
    localparam int BYTE_WORD = LANE / 2;                // 8 bpp, two pixels per word
    localparam int BYTE_LSB  = 8 - 8 * (LANE % 2);      // high byte first

    word_t  nib_word;
    word_t  byte_word;
    attr_t  attr;
    color_t index;

    always_comb begin
        nib_word  = bundle_if.words[NIB_WORD];
        byte_word = bundle_if.words[BYTE_WORD];
        attr      = attr_t'(bundle_if.words[0][ATTR_LSB +: 8]);
        case (bundle_if.mode)
            BPP_1_ATTR: begin
                // pixel bit picks fore or back colour
                index = {4'h0, bundle_if.words[0][BIT_POS] ? attr.fore : attr.back};
            end
            BPP_4: begin
                index = {4'h0, nib_word[NIB_LSB +: 4]};
            end
            default: begin
                index = byte_word[BYTE_LSB +: 8];       // 8 bpp and code 3
            end
        endcase
        pixel_o = index ^ colorbase_i;
    end

endmodule

/* source/scanout_shifter.sv */
// Two-stage pixel buffer feeding the output stream.
// A pending buffer takes each bundle, the shift register emits its eight
// pixels h_repeat+1 times each under valid/ready, and line end is flagged.

`include "playfield_macros.svh"

module scanout_shifter
    import pf_video_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [`PF_REP_W-1:0]    h_repeat_i,         // extra copies of each pixel
    input  logic                    line_fetched_i,     // fetch has handed off the last group
    pixel_row_if.sink               row_if,
    word_bundle_if.sink_ready       bundle_if,
    output color_t                  pixel_o,
    output logic                    pixel_valid_o,
    input  logic                    pixel_ready_i,
    output logic                    line_done_o         // one cycle after last pixel taken
);

    localparam int POS_W = $clog2(`PF_LANES);

    color_t [`PF_LANES-1:0] pend_q;                     // next group, expanded
    color_t [`PF_LANES-1:0] shift_q;                    // group on output, [0] is current
    logic                   pend_full_q;
    logic                   active_q;                   // shift register holds pixels
    logic                   line_fetched_q;             // waiting for buffers to drain
    logic [POS_W-1:0]       pos_q;                      // pixel position in group
    logic [`PF_REP_W-1:0]   rep_q;                      // copies of current pixel sent
    logic                   consume;
    logic                   last_rep;
    logic                   group_end;
    logic                   load_shift;
    logic                   take_bundle;

    always_comb begin
        consume     = active_q && pixel_ready_i;
        last_rep    = (rep_q == h_repeat_i);
        group_end   = consume && last_rep && (pos_q == POS_W'(`PF_LANES - 1));
        load_shift  = pend_full_q && (!active_q || group_end);  // no bubble between groups
        take_bundle = bundle_if.valid && !pend_full_q;
    end

    assign bundle_if.ready = !pend_full_q;
    assign pixel_o         = shift_q[0];
    assign pixel_valid_o   = active_q;
    assign line_done_o     = line_fetched_q && !active_q && !pend_full_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pend_full_q    <= 1'b0;
            active_q       <= 1'b0;
            line_fetched_q <= 1'b0;
            pos_q          <= '0;
            rep_q          <= '0;
        end else begin
            if (take_bundle) begin
                pend_q      <= row_if.pixels;           // lanes show the bundle this cycle
                pend_full_q <= 1'b1;
            end

            if (consume) begin
                if (last_rep) begin
                    rep_q   <= '0;
                    pos_q   <= pos_q + 1'b1;            // wraps to 0 at group end
                    shift_q <= {color_t'(0), shift_q[`PF_LANES-1:1]};
                end else begin
                    rep_q   <= rep_q + 1'b1;
                end
            end

            if (group_end) begin
                active_q <= 1'b0;                       // overridden by a reload below
            end

            if (load_shift) begin
                shift_q     <= pend_q;
                pos_q       <= '0;
                rep_q       <= '0;
                active_q    <= 1'b1;
                pend_full_q <= 1'b0;
            end

            if (line_done_o) begin
                line_fetched_q <= 1'b0;
            end
            if (line_fetched_i) begin
                line_fetched_q <= 1'b1;
            end
        end
    end

endmodule

/* source/video_playfield.sv */
// Bitmap playfield line generator, top level.
// Fetch over Wishbone, eight expansion lanes and the scanout shifter,
// exposed as plain ports with a valid/ready pixel stream.

`include "playfield_macros.svh"

module video_playfield
    import pf_video_pkg::*;
    import pf_bus_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_i,
    // line and frame control
    input  logic                    line_start_i,
    input  logic                    frame_start_i,
    input  addr_t                   start_addr_i,
    input  word_t                   line_len_i,
    input  logic [`PF_GROUPS_W-1:0] groups_i,
    input  bpp_mode_e               mode_i,
    input  color_t                  colorbase_i,
    input  logic [`PF_REP_W-1:0]    h_repeat_i,
    input  logic [`PF_REP_W-1:0]    v_repeat_i,
    output logic                    line_done_o,
    // Wishbone classic read master
    output logic                    wb_cyc_o,
    output logic                    wb_stb_o,
    output logic                    wb_we_o,
    output addr_t                   wb_adr_o,
    input  word_t                   wb_dat_i,
    input  logic                    wb_ack_i,
    // pixel stream
    output color_t                  pixel_o,
    output logic                    pixel_valid_o,
    input  logic                    pixel_ready_i
);

    logic line_fetched;                                 // fetch to shifter, last group gone

    word_bundle_if bundle_if ();
    pixel_row_if   row_if ();

    display_fetch display_fetch_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .line_start_i   (line_start_i),
        .frame_start_i  (frame_start_i),
        .start_addr_i   (start_addr_i),
        .line_len_i     (line_len_i),
        .groups_i       (groups_i),
        .mode_i         (mode_i),
        .v_repeat_i     (v_repeat_i),
        .wb_cyc_o       (wb_cyc_o),
        .wb_stb_o       (wb_stb_o),
        .wb_we_o        (wb_we_o),
        .wb_adr_o       (wb_adr_o),
        .wb_dat_i       (wb_dat_i),
        .wb_ack_i       (wb_ack_i),
        .line_fetched_o (line_fetched),
        .bundle_if      (bundle_if)
    );

    // one lane per pixel of the group, lane 0 leftmost
    for (genvar g = 0; g < `PF_LANES; g++) begin : g_lane
        pixel_lane_expand #(
            .LANE       (g)
        ) pixel_lane_expand_i (
            .colorbase_i(colorbase_i),
            .bundle_if  (bundle_if),
            .pixel_o    (row_if.pixels[g])
        );
    end

    scanout_shifter scanout_shifter_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .h_repeat_i     (h_repeat_i),
        .line_fetched_i (line_fetched),
        .row_if         (row_if),
        .bundle_if      (bundle_if),
        .pixel_o        (pixel_o),
        .pixel_valid_o  (pixel_valid_o),
        .pixel_ready_i  (pixel_ready_i),
        .line_done_o    (line_done_o)
    );

endmodule

/* verification/tb_playfield_tasks.svh */
// Directed tests for the playfield, included inside tb_video_playfield.
// Expected pixels are rebuilt from the VRAM image with the depth rules.

task automatic compare_color(input string name, input color_t got, input color_t exp);
    if (got !== exp) begin
        $display("error: %s got %h expected %h", name, got, exp);
        err_cnt++;
    end
endtask

task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
        $display("error: %s got %h expected %h", name, got, exp);
        err_cnt++;
    end
endtask

// reference pixels of one line with each one repeated reps+1 times
task automatic expect_line(input addr_t base, input int groups, input bpp_mode_e mode,
                           input color_t cbase, input int reps);
    word_t  w;
    color_t c;
    for (int g = 0; g < groups; g++) begin
        for (int p = 0; p < `PF_LANES; p++) begin
            case (mode)
                BPP_1_ATTR: begin
                    w = vram[addr_t'(base + g)];
                    c = w[7 - p] ? color_t'(w[11:8]) : color_t'(w[15:12]);  // set bit is fore
                end
                BPP_4: begin
                    w = vram[addr_t'(base + 2 * g + p / 4)];
                    c = color_t'((w >> (12 - 4 * (p % 4))) & 16'h000f);
                end
                default: begin
                    w = vram[addr_t'(base + 4 * g + p / 2)];
                    c = (p % 2 == 0) ? w[15:8] : w[7:0];                 // high byte first
                end
            endcase
            repeat (reps + 1) exp_pix.push_back(c ^ cbase);
        end
    end
endtask

task automatic check_pixels();
    if (got_pix.size() != exp_pix.size()) begin
        $display("%0d pixels consumed where %0d were expected", got_pix.size(),
                 exp_pix.size());
        err_cnt++;
    end else begin
        foreach (exp_pix[i]) compare_color("pixel_o", got_pix[i], exp_pix[i]);
    end
    got_pix.delete();
    exp_pix.delete();
endtask

task automatic line_8bpp();
    int errs;
    errs = err_cnt;
    new_frame(16'h0100, 16'd12, 2'd0);
    expect_line(16'h0100, 3, BPP_8, 8'h5a, 0);
    play_line(3, BPP_8, 8'h5a, 2'd0);
    if (adr_log.size() != 12) begin
        $display("%0d bus reads where 12 were expected", adr_log.size());
        err_cnt++;
    end else begin
        foreach (adr_log[i]) compare_addr("wb_adr_o", adr_log[i], addr_t'(16'h0100 + i));
    end
    check_pixels();
    report("8 bpp line", errs);
endtask

task automatic line_4bpp();
    int errs;
    errs = err_cnt;
    new_frame(16'h0400, 16'd8, 2'd0);
    expect_line(16'h0400, 4, BPP_4, 8'hc3, 0);
    play_line(4, BPP_4, 8'hc3, 2'd0);
    check_pixels();
    report("4 bpp line", errs);
endtask

task automatic line_1bpp_attr();
    int errs;
    errs = err_cnt;
    new_frame(16'h0800, 16'd4, 2'd0);
    expect_line(16'h0800, 4, BPP_1_ATTR, 8'h10, 0);
    play_line(4, BPP_1_ATTR, 8'h10, 2'd0);
    check_pixels();
    report("1 bpp attribute line", errs);
endtask

task automatic h_repeat_backpressure();
    int errs;
    errs = err_cnt;
    new_frame(16'h1000, 16'd8, 2'd0);
    expect_line(16'h1000, 2, BPP_8, 8'h00, 2);         // three copies of each pixel
    drop_en = 1'b1;
    play_line(2, BPP_8, 8'h00, 2'd2);
    drop_en = 1'b0;
    check_pixels();
    report("h repeat with back-pressure", errs);
endtask

task automatic v_repeat_lines();
    int    errs;
    addr_t base;
    errs  = err_cnt;
    new_frame(16'h2000, 16'd40, 2'd1);
    for (int l = 0; l < 4; l++) begin
        base = addr_t'(16'h2000 + (l / 2) * 40);        // each line shown twice
        expect_line(base, 2, BPP_4, 8'h30, 0);
        play_line(2, BPP_4, 8'h30, 2'd0);
        compare_addr("wb_adr_o", adr_log[0], base);
        check_pixels();
    end
    report("v repeat over four lines", errs);
endtask

/* verification/tb_video_playfield.sv */
// Testbench for the playfield line generator.
// Models video RAM as a Wishbone slave with random ack delay, collects the
// pixel stream and runs the directed tests from tb_playfield_tasks.svh.

`include "playfield_macros.svh"

module tb_video_playfield
    import pf_video_pkg::*;
    import pf_bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 16;
    localparam int N_LINES      = 8;                    // one line each in tests 1 to 4, four in 5
    localparam int MAX_GROUPS   = 4;
    // up to 6 cycles per word and 3 copies per pixel at 3/4 ready
    localparam int LINE_CYCLES  = MAX_GROUPS * (`PF_MAX_WORDS * 6 + `PF_LANES * 3 * 2);
    localparam int TIMEOUT      = RESET_CYCLES + 2 * N_LINES * LINE_CYCLES;

    logic                    clk = 1'b0;
    logic                    reset_i;
    logic                    line_start_i;
    logic                    frame_start_i;
    addr_t                   start_addr_i;
    word_t                   line_len_i;
    logic [`PF_GROUPS_W-1:0] groups_i;
    bpp_mode_e               mode_i;
    color_t                  colorbase_i;
    logic [`PF_REP_W-1:0]    h_repeat_i;
    logic [`PF_REP_W-1:0]    v_repeat_i;
    logic                    line_done_o;
    logic                    wb_cyc_o;
    logic                    wb_stb_o;
    logic                    wb_we_o;
    addr_t                   wb_adr_o;
    word_t                   wb_dat_i;
    logic                    wb_ack_i;
    color_t                  pixel_o;
    logic                    pixel_valid_o;
    logic                    pixel_ready_i;

    word_t  vram [0:(1 << `PF_ADDR_W) - 1];             // whole word address space
    addr_t  adr_log[$];                                 // acked read addresses of a line
    color_t got_pix[$];                                 // consumed pixels
    color_t exp_pix[$];
    int     seed      = 32'h533;
    int     drop_seed = 32'h533;                        // separate stream for the ready pattern
    int     wait_left = 0;
    bit     drop_en   = 1'b0;
    int     done_cnt  = 0;
    int     err_cnt   = 0;
    int     pass_cnt  = 0;
    int     fail_cnt  = 0;
    int     cycle_cnt = 0;

    video_playfield video_playfield_i (.*);

    always #2 clk = ~clk;

    // Wishbone slave with one read per cyc/stb and 0 to 3 wait cycles
    initial begin
        wb_ack_i = 1'b0;
        wb_dat_i = '0;
        for (int a = 0; a < (1 << `PF_ADDR_W); a++) begin
            vram[a] = word_t'($random(seed));
        end
        forever begin
            @(posedge clk);
            #1;
            if (wb_cyc_o !== wb_stb_o) begin            // cyc and stb move together
                $display("error: wb_stb_o got %h expected %h", wb_stb_o, wb_cyc_o);
                err_cnt++;
            end
            if (wb_ack_i || !wb_cyc_o || !wb_stb_o) begin
                wb_ack_i  = 1'b0;                       // master drops cyc after ack
                wait_left = $unsigned($random(seed)) % 4;
            end else if (wait_left == 0) begin
                if (wb_we_o !== 1'b0) begin
                    $display("error: wb_we_o got %h expected %h", wb_we_o, 1'b0);
                    err_cnt++;
                end
                wb_ack_i = 1'b1;
                wb_dat_i = vram[wb_adr_o];
                adr_log.push_back(wb_adr_o);
            end else begin
                wait_left--;
            end
        end
    end

    // random back-pressure drops about one cycle in four
    always @(posedge clk) begin
        #1;
        pixel_ready_i = drop_en ? ($unsigned($random(drop_seed)) % 4 != 0) : 1'b1;
    end

    // sample mid cycle since a transfer completes at the next rising edge
    always @(negedge clk) begin
        if (!reset_i && pixel_valid_o && pixel_ready_i) begin
            got_pix.push_back(pixel_o);
        end
        if (!reset_i && line_done_o) begin
            done_cnt++;
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic new_frame(input addr_t start, input word_t len,
                             input logic [`PF_REP_W-1:0] v_rep);
        start_addr_i  = start;
        line_len_i    = len;
        v_repeat_i    = v_rep;                          // also reloaded at each line end
        frame_start_i = 1'b1;
        step();
        frame_start_i = 1'b0;
    endtask

    // start one line and wait for its line_done_o
    task automatic play_line(input int groups, input bpp_mode_e mode, input color_t cbase,
                             input logic [`PF_REP_W-1:0] h_rep);
        int dones;
        dones        = done_cnt;
        adr_log.delete();
        groups_i     = `PF_GROUPS_W'(groups);
        mode_i       = mode;
        colorbase_i  = cbase;
        h_repeat_i   = h_rep;
        line_start_i = 1'b1;
        step();
        line_start_i = 1'b0;
        while (done_cnt == dones) begin
            step();
        end
        repeat (4) step();                              // room for a stray second pulse
        if (done_cnt != dones + 1) begin
            $display("line_done_o pulsed %0d times for one line", done_cnt - dones);
            err_cnt++;
        end
    endtask

    task automatic report(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("%s: pass", name);
            pass_cnt++;
        end else begin
            $display("%s: %0d errors", name, err_cnt - errs_before);
            fail_cnt++;
        end
    endtask

    `include "tb_playfield_tasks.svh"

    initial begin : watchdog
        while (cycle_cnt < TIMEOUT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("no line end after %0d cycles, run stopped", TIMEOUT);
        $display("Test FAILED");
        $finish;
    end

    initial begin : run_tests
        reset_i       = 1'b1;
        line_start_i  = 1'b0;
        frame_start_i = 1'b0;
        start_addr_i  = '0;
        line_len_i    = '0;
        groups_i      = '0;
        mode_i        = BPP_8;
        colorbase_i   = '0;
        h_repeat_i    = '0;
        v_repeat_i    = '0;
        pixel_ready_i = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_i = 1'b0;
        step();
        line_8bpp();
        line_4bpp();
        line_1bpp_attr();
        h_repeat_backpressure();
        v_repeat_lines();
        $display("%0d tests passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* video_playfield.f */
+incdir+source
+incdir+verification
source/pf_video_pkg.sv
source/pf_bus_pkg.sv
source/pf_ifs.sv
source/display_fetch.sv
source/pixel_lane_expand.sv
source/scanout_shifter.sv
source/video_playfield.sv
verification/tb_video_playfield.sv

/* Bender.yml */
package:
  name: video_playfield

sources:
  - include_dirs:
      - source
    files:
      - source/pf_video_pkg.sv
      - source/pf_bus_pkg.sv
      - source/pf_ifs.sv
      - source/display_fetch.sv
      - source/pixel_lane_expand.sv
      - source/scanout_shifter.sv
      - source/video_playfield.sv
  - target: test
    include_dirs:
      - source
      - verification
    files:
      - verification/tb_video_playfield.sv
